// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
TOP       := tb_id_stage
FILELIST  := vlog.f

BIN  := obj_dir/V$(TOP)
SRCS := $(wildcard src/*.sv src/*.svh tb/*.sv tb/*.svh)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -qx "Finished with no errors"

clean:
	rm -rf obj_dir

// ==== src/id_branch_unit.sv ====
// Branch resolution in decode, evaluates the condition and reports the taken target to fetch
`include "id_params.svh"

module id_branch_unit (
  input  logic                 i_valid,
  input  logic [`XLEN-1:0]     i_pc,
  input  logic [`XLEN-1:0]     i_imm,
  input  logic [`XLEN-1:0]     i_rs1data,
  input  logic [`XLEN-1:0]     i_rs2data,
  input  logic                 i_bren,
  input  rv_isa_pkg::br_func_e i_brfunc,
  input  logic                 i_jal,
  output id_bus_pkg::br_bus_t  o_br_bus
);

  import rv_isa_pkg::*;

  logic cond;

  always_comb begin
    case (i_brfunc)
      BR_EQ:   cond = i_rs1data == i_rs2data;
      BR_NE:   cond = i_rs1data != i_rs2data;
      BR_LT:   cond = $signed(i_rs1data) < $signed(i_rs2data);
      BR_GE:   cond = $signed(i_rs1data) >= $signed(i_rs2data);
      default: cond = 1'b0;
    endcase
  end

  // jal is unconditional, branches need bren
  assign o_br_bus.taken  = i_valid && ((i_bren && cond) || i_jal);
  assign o_br_bus.target = i_pc + i_imm; // same adder for b and j offsets

endmodule

// ==== src/id_bus_pkg.sv ====
// Bus bundles between the pipeline stages around decode, used on every stage port
`include "id_params.svh"

package id_bus_pkg;

  // fetch -> decode
  typedef struct packed {
    logic [`INST_WD-1:0] inst;
    logic [`XLEN-1:0]    pc;
  } fs_to_ds_t;

  // write back -> register file
  typedef struct packed {
    logic                    wen;
    logic [`GPR_ADDR_WD-1:0] waddr;
    logic [`XLEN-1:0]        wdata;
  } wb_to_rf_t;

  typedef struct packed {
    logic [`GPR_ADDR_WD-1:0] rs1;
    logic [`GPR_ADDR_WD-1:0] rs2;
    logic [`GPR_ADDR_WD-1:0] rd;
    logic [`XLEN-1:0]        imm;
    rv_isa_pkg::alu_op_e     alu_op;
    logic                    alu_src1_pc;  // pc instead of rs1
    logic                    alu_src2_imm; // imm instead of rs2
    logic                    gpr_wen;
    logic                    bren;
    logic                    jal;          // execute links pc + 4
    logic                    invalid;
  } dec_ctrl_t;

  // decode -> execute
  typedef struct packed {
    logic [`XLEN-1:0] rs1data;
    logic [`XLEN-1:0] rs2data;
    logic [`XLEN-1:0] pc;
    dec_ctrl_t        ctrl;
  } ds_to_es_t;

  // decode -> fetch
  typedef struct packed {
    logic             taken;
    logic [`XLEN-1:0] target;
  } br_bus_t;

endpackage

// ==== src/id_decoder.sv ====
// Instruction decoder for the RV64I subset, turns the latched word into execute control fields
`include "id_params.svh"

module id_decoder (
  input  rv_isa_pkg::rv_inst_u  i_inst,
  output id_bus_pkg::dec_ctrl_t o_ctrl
);

  import rv_isa_pkg::*;

  logic [`XLEN-1:0] imm_i;
  logic [`XLEN-1:0] imm_b;
  logic [`XLEN-1:0] imm_u;
  logic [`XLEN-1:0] imm_j;
  logic             invalid;

  // sign extended immediates, one per format view
  assign imm_i = {{(`XLEN-12){i_inst.i.imm[11]}}, i_inst.i.imm};
  assign imm_b = {{(`XLEN-13){i_inst.b.imm_12}}, i_inst.b.imm_12, i_inst.b.imm_11,
                  i_inst.b.imm_10_5, i_inst.b.imm_4_1, 1'b0};
  assign imm_u = {{(`XLEN-32){i_inst.u.imm[19]}}, i_inst.u.imm, 12'b0};
  assign imm_j = {{(`XLEN-21){i_inst.j.imm_20}}, i_inst.j.imm_20, i_inst.j.imm_19_12,
                  i_inst.j.imm_11, i_inst.j.imm_10_1, 1'b0};

  always_comb begin
    o_ctrl  = '0; // unused sources stay x0 so they never stall
    invalid = 1'b0;
    case (i_inst.r.opcode)
      OPC_LUI: begin
        o_ctrl.rd           = i_inst.u.rd;
        o_ctrl.imm          = imm_u;
        o_ctrl.alu_op       = ALU_PASS_B;
        o_ctrl.alu_src2_imm = 1'b1;
        o_ctrl.gpr_wen      = 1'b1;
      end
      OPC_JAL: begin
        o_ctrl.rd          = i_inst.j.rd;
        o_ctrl.imm         = imm_j;
        o_ctrl.alu_op      = ALU_ADD;
        o_ctrl.alu_src1_pc = 1'b1;
        o_ctrl.gpr_wen     = 1'b1;
        o_ctrl.jal         = 1'b1;
      end
      OPC_BRANCH: begin
        o_ctrl.rs1    = i_inst.b.rs1;
        o_ctrl.rs2    = i_inst.b.rs2;
        o_ctrl.imm    = imm_b;
        o_ctrl.alu_op = ALU_SUB;
        o_ctrl.bren   = 1'b1;
        invalid       = !(i_inst.b.funct3 inside {BR_EQ, BR_NE, BR_LT, BR_GE});
      end
      OPC_OP_IMM: begin
        o_ctrl.rs1          = i_inst.i.rs1;
        o_ctrl.rd           = i_inst.i.rd;
        o_ctrl.imm          = imm_i;
        o_ctrl.alu_op       = ALU_ADD;
        o_ctrl.alu_src2_imm = 1'b1;
        o_ctrl.gpr_wen      = 1'b1;
        invalid             = i_inst.i.funct3 != F3_ADD_SUB; // addi only
      end
      OPC_OP: begin
        o_ctrl.rs1     = i_inst.r.rs1;
        o_ctrl.rs2     = i_inst.r.rs2;
        o_ctrl.rd      = i_inst.r.rd;
        o_ctrl.gpr_wen = 1'b1;
        case ({i_inst.r.funct7, i_inst.r.funct3})
          {F7_BASE, F3_ADD_SUB}: o_ctrl.alu_op = ALU_ADD;
          {F7_SUB, F3_ADD_SUB}:  o_ctrl.alu_op = ALU_SUB;
          {F7_BASE, F3_AND}:     o_ctrl.alu_op = ALU_AND;
          {F7_BASE, F3_OR}:      o_ctrl.alu_op = ALU_OR;
          default:               invalid = 1'b1;
        endcase
      end
      default: invalid = 1'b1;
    endcase

    // outside the subset, nothing may be enabled
    if (invalid) begin
      o_ctrl         = '0;
      o_ctrl.invalid = 1'b1;
    end
  end

endmodule

// ==== src/id_gpr_file.sv ====
// General register file of the decode stage, two combinational reads and one write from write back
`include "id_params.svh"

module id_gpr_file (
  input  logic                    i_clk,
  input  logic                    i_arst_n,
  input  logic [`GPR_ADDR_WD-1:0] i_raddr1,
  input  logic [`GPR_ADDR_WD-1:0] i_raddr2,
  input  id_bus_pkg::wb_to_rf_t   i_wb,
  output logic [`XLEN-1:0]        o_rdata1,
  output logic [`XLEN-1:0]        o_rdata2
);

  logic [`XLEN-1:0] regs [1:`GPR_NUM-1]; // x0 has no storage

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int i = 1; i < `GPR_NUM; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wb.wen && i_wb.waddr != '0) begin // x0 never written
      regs[i_wb.waddr] <= i_wb.wdata;
    end
  end

  // x0 reads as zero
  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

endmodule

// ==== src/id_params.svh ====
// ISA widths and register count for the decode stage, included by the packages and RTL
`ifndef ID_PARAMS_SVH
`define ID_PARAMS_SVH

// data path width of RV64
`define XLEN 64

// raw instruction width
`define INST_WD 32

// general register file
`define GPR_ADDR_WD 5
`define GPR_NUM 32

`endif

// ==== src/id_stage.sv ====
// Top of the decode stage, wires the stage register, decoder, register file and branch unit
`include "id_params.svh"

module id_stage (
  input  logic                    i_clk,
  input  logic                    i_arst_n,
  input  logic                    i_fs_to_ds_valid,
  input  id_bus_pkg::fs_to_ds_t   i_fs_to_ds_bus,
  input  logic                    i_es_allowin,
  input  id_bus_pkg::wb_to_rf_t   i_wb_to_rf,
  input  logic [`GPR_ADDR_WD-1:0] i_es_rd,
  input  logic [`GPR_ADDR_WD-1:0] i_ms_rd,
  input  logic [`GPR_ADDR_WD-1:0] i_ws_rd,
  output logic                    o_ds_allowin,
  output logic                    o_ds_to_es_valid,
  output id_bus_pkg::ds_to_es_t   o_ds_to_es_bus,
  output id_bus_pkg::br_bus_t     o_br_bus
);

  import rv_isa_pkg::*;
  import id_bus_pkg::*;

  rv_inst_u         ds_inst;
  logic [`XLEN-1:0] ds_pc;
  logic [`XLEN-1:0] rs1data;
  logic [`XLEN-1:0] rs2data;
  dec_ctrl_t        dec_ctrl;

  id_stage_ctrl u_stage_ctrl (
    .i_clk            (i_clk),
    .i_arst_n         (i_arst_n),
    .i_fs_to_ds_valid (i_fs_to_ds_valid),
    .i_fs_to_ds_bus   (i_fs_to_ds_bus),
    .i_es_allowin     (i_es_allowin),
    .i_es_rd          (i_es_rd),
    .i_ms_rd          (i_ms_rd),
    .i_ws_rd          (i_ws_rd),
    .i_rs1            (dec_ctrl.rs1),
    .i_rs2            (dec_ctrl.rs2),
    .o_ds_allowin     (o_ds_allowin),
    .o_ds_to_es_valid (o_ds_to_es_valid),
    .o_ds_inst        (ds_inst),
    .o_ds_pc          (ds_pc)
  );

  id_decoder u_decoder (
    .i_inst (ds_inst),
    .o_ctrl (dec_ctrl)
  );

  id_gpr_file u_gprs (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_raddr1 (dec_ctrl.rs1),
    .i_raddr2 (dec_ctrl.rs2),
    .i_wb     (i_wb_to_rf),
    .o_rdata1 (rs1data),
    .o_rdata2 (rs2data)
  );

  id_branch_unit u_bru (
    .i_valid   (o_ds_to_es_valid),
    .i_pc      (ds_pc),
    .i_imm     (dec_ctrl.imm),
    .i_rs1data (rs1data),
    .i_rs2data (rs2data),
    .i_bren    (dec_ctrl.bren),
    .i_brfunc  (ds_inst.b.funct3), // funct3 seen through the branch view
    .i_jal     (dec_ctrl.jal),
    .o_br_bus  (o_br_bus)
  );

  assign o_ds_to_es_bus = '{rs1data: rs1data, rs2data: rs2data, pc: ds_pc, ctrl: dec_ctrl};

endmodule

// ==== src/id_stage_ctrl.sv ====
// Decode stage register with valid/allowin handshake and the stall on pending register writes
`include "id_params.svh"

module id_stage_ctrl (
  input  logic                    i_clk,
  input  logic                    i_arst_n,
  input  logic                    i_fs_to_ds_valid,
  input  id_bus_pkg::fs_to_ds_t   i_fs_to_ds_bus,
  input  logic                    i_es_allowin,
  input  logic [`GPR_ADDR_WD-1:0] i_es_rd,
  input  logic [`GPR_ADDR_WD-1:0] i_ms_rd,
  input  logic [`GPR_ADDR_WD-1:0] i_ws_rd,
  input  logic [`GPR_ADDR_WD-1:0] i_rs1,
  input  logic [`GPR_ADDR_WD-1:0] i_rs2,
  output logic                    o_ds_allowin,
  output logic                    o_ds_to_es_valid,
  output rv_isa_pkg::rv_inst_u    o_ds_inst,
  output logic [`XLEN-1:0]        o_ds_pc
);

  import id_bus_pkg::*;

  logic      ds_valid;
  logic      ds_ready_go;
  fs_to_ds_t ds_bus_r;

  // later stage still owes a write to one of our sources
  function automatic logic dest_hit(input logic [`GPR_ADDR_WD-1:0] rd);
    return (rd != '0) && (rd == i_rs1 || rd == i_rs2);
  endfunction

  assign ds_ready_go      = !(dest_hit(i_es_rd) || dest_hit(i_ms_rd) || dest_hit(i_ws_rd));
  assign o_ds_allowin     = !ds_valid || (ds_ready_go && i_es_allowin);
  assign o_ds_to_es_valid = ds_valid && ds_ready_go;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      ds_valid <= 1'b0;
    end else if (o_ds_allowin) begin
      ds_valid <= i_fs_to_ds_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_fs_to_ds_valid && o_ds_allowin) begin
      ds_bus_r <= i_fs_to_ds_bus;
    end
  end

  assign o_ds_inst = ds_bus_r.inst;
  assign o_ds_pc   = ds_bus_r.pc;

endmodule

// ==== src/rv_isa_pkg.sv ====
// RV64I instruction formats and decode encodings shared by the decode stage modules
`include "id_params.svh"

package rv_isa_pkg;

  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_PASS_B // lui
  } alu_op_e;

  // same encoding as funct3 of the branch format
  typedef enum logic [2:0] {
    BR_EQ = 3'b000,
    BR_NE = 3'b001,
    BR_LT = 3'b100,
    BR_GE = 3'b101
  } br_func_e;

  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;
  localparam logic [6:0] F7_BASE    = 7'b0000000;
  localparam logic [6:0] F7_SUB     = 7'b0100000;

  typedef struct packed {
    logic [6:0]              funct7;
    logic [`GPR_ADDR_WD-1:0] rs2;
    logic [`GPR_ADDR_WD-1:0] rs1;
    logic [2:0]              funct3;
    logic [`GPR_ADDR_WD-1:0] rd;
    opcode_e                 opcode;
  } inst_r_t;

  typedef struct packed {
    logic [11:0]             imm;
    logic [`GPR_ADDR_WD-1:0] rs1;
    logic [2:0]              funct3;
    logic [`GPR_ADDR_WD-1:0] rd;
    opcode_e                 opcode;
  } inst_i_t;

  typedef struct packed {
    logic                    imm_12;
    logic [5:0]              imm_10_5;
    logic [`GPR_ADDR_WD-1:0] rs2;
    logic [`GPR_ADDR_WD-1:0] rs1;
    br_func_e                funct3;
    logic [3:0]              imm_4_1;
    logic                    imm_11;
    opcode_e                 opcode;
  } inst_b_t;

  typedef struct packed {
    logic [19:0]             imm;
    logic [`GPR_ADDR_WD-1:0] rd;
    opcode_e                 opcode;
  } inst_u_t;

  typedef struct packed {
    logic                    imm_20;
    logic [9:0]              imm_10_1;
    logic                    imm_11;
    logic [7:0]              imm_19_12;
    logic [`GPR_ADDR_WD-1:0] rd;
    opcode_e                 opcode;
  } inst_j_t;

  typedef union packed {
    inst_r_t r;
    inst_i_t i;
    inst_b_t b;
    inst_u_t u;
    inst_j_t j;
  } rv_inst_u;

endpackage

// ==== tb/id_ref_model.svh ====
// Reference decode model and shadow register file, included inside the decode stage testbench
`ifndef ID_REF_MODEL_SVH
`define ID_REF_MODEL_SVH

// follows every write back that the testbench drives
logic [`XLEN-1:0] shadow_gpr [`GPR_NUM] = '{default: '0};

function automatic void shadow_write(input wb_to_rf_t w);
  if (w.wen && w.waddr != '0) begin
    shadow_gpr[w.waddr] = w.wdata; // x0 stays zero
  end
endfunction

// expected execute bundle and branch bundle for one instruction word
function automatic void ref_decode(input logic [31:0] inst, input logic [`XLEN-1:0] pc,
                                   input logic [`XLEN-1:0] gpr [`GPR_NUM],
                                   output ds_to_es_t bus, output br_bus_t br);
  logic [`XLEN-1:0] a;
  logic [`XLEN-1:0] b;
  logic             cond;
  logic             ok;
  bus  = '0;
  cond = 1'b0;
  ok   = 1'b1;
  a    = gpr[inst[19:15]];
  b    = gpr[inst[24:20]];
  case (inst[6:0])
    7'b0110111: begin // lui
      bus.ctrl.rd           = inst[11:7];
      bus.ctrl.imm          = {{32{inst[31]}}, inst[31:12], 12'h000};
      bus.ctrl.alu_op       = ALU_PASS_B;
      bus.ctrl.alu_src2_imm = 1'b1;
      bus.ctrl.gpr_wen      = 1'b1;
    end
    7'b1101111: begin // jal
      bus.ctrl.rd          = inst[11:7];
      bus.ctrl.imm         = {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
      bus.ctrl.alu_op      = ALU_ADD;
      bus.ctrl.alu_src1_pc = 1'b1;
      bus.ctrl.gpr_wen     = 1'b1;
      bus.ctrl.jal         = 1'b1;
      cond                 = 1'b1;
    end
    7'b1100011: begin // conditional branches
      bus.ctrl.rs1    = inst[19:15];
      bus.ctrl.rs2    = inst[24:20];
      bus.ctrl.imm    = {{52{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
      bus.ctrl.alu_op = ALU_SUB;
      bus.ctrl.bren   = 1'b1;
      case (inst[14:12])
        3'b000:  cond = a == b;
        3'b001:  cond = a != b;
        3'b100:  cond = $signed(a) < $signed(b);
        3'b101:  cond = $signed(a) >= $signed(b);
        default: ok = 1'b0;
      endcase
    end
    7'b0010011: begin // addi only
      bus.ctrl.rs1          = inst[19:15];
      bus.ctrl.rd           = inst[11:7];
      bus.ctrl.imm          = {{52{inst[31]}}, inst[31:20]};
      bus.ctrl.alu_op       = ALU_ADD;
      bus.ctrl.alu_src2_imm = 1'b1;
      bus.ctrl.gpr_wen      = 1'b1;
      ok                    = inst[14:12] == 3'b000;
    end
    7'b0110011: begin
      bus.ctrl.rs1     = inst[19:15];
      bus.ctrl.rs2     = inst[24:20];
      bus.ctrl.rd      = inst[11:7];
      bus.ctrl.gpr_wen = 1'b1;
      if ({inst[31:25], inst[14:12]} == {7'h00, 3'b000}) bus.ctrl.alu_op = ALU_ADD;
      else if ({inst[31:25], inst[14:12]} == {7'h20, 3'b000}) bus.ctrl.alu_op = ALU_SUB;
      else if ({inst[31:25], inst[14:12]} == {7'h00, 3'b111}) bus.ctrl.alu_op = ALU_AND;
      else if ({inst[31:25], inst[14:12]} == {7'h00, 3'b110}) bus.ctrl.alu_op = ALU_OR;
      else ok = 1'b0;
    end
    default: ok = 1'b0;
  endcase
  if (!ok) begin
    bus              = '0;
    bus.ctrl.invalid = 1'b1;
    cond             = 1'b0;
  end
  bus.rs1data = gpr[bus.ctrl.rs1];
  bus.rs2data = gpr[bus.ctrl.rs2];
  bus.pc      = pc;
  br.taken    = cond;
  br.target   = pc + bus.ctrl.imm;
endfunction

`endif

// ==== tb/tb_id_stage.sv ====
// Testbench for the decode stage, drives fetch and write back and checks the execute and branch buses
`include "id_params.svh"

module tb_id_stage;
  timeunit 1ns;
  timeprecision 100ps;

  import rv_isa_pkg::*;
  import id_bus_pkg::*;

  logic        clk;
  logic        arst_n;
  logic        fs_valid;
  fs_to_ds_t   fs_bus;
  logic        es_allowin;
  wb_to_rf_t   wb;
  logic [4:0]  es_rd;
  logic [4:0]  ms_rd;
  logic [4:0]  ws_rd;
  logic        ds_allowin;
  logic        es_valid;
  ds_to_es_t   es_bus;
  br_bus_t     br_bus;
  int          errors = 0;
  int          accepted = 0;
  int          emitted = 0;
  fs_to_ds_t   inflight [$]; // accepted, not yet passed to execute

  `include "id_ref_model.svh"

  id_stage id_stage_inst (
    .i_clk            (clk),
    .i_arst_n         (arst_n),
    .i_fs_to_ds_valid (fs_valid),
    .i_fs_to_ds_bus   (fs_bus),
    .i_es_allowin     (es_allowin),
    .i_wb_to_rf       (wb),
    .i_es_rd          (es_rd),
    .i_ms_rd          (ms_rd),
    .i_ws_rd          (ws_rd),
    .o_ds_allowin     (ds_allowin),
    .o_ds_to_es_valid (es_valid),
    .o_ds_to_es_bus   (es_bus),
    .o_br_bus         (br_bus)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic check(input string name, input logic [511:0] got, input logic [511:0] want);
    if (got !== want) begin
      $display("Fail %s got %0h expected %0h", name, got, want);
      errors++;
    end
  endtask

  function automatic logic [31:0] alu_reg_inst(input logic [6:0] f7, input logic [4:0] rs2,
                                               input logic [4:0] rs1, input logic [2:0] f3,
                                               input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] addi_inst(input logic [11:0] imm, input logic [4:0] rs1,
                                            input logic [4:0] rd);
    return {imm, rs1, 3'b000, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] lui_inst(input logic [19:0] hi, input logic [4:0] rd);
    return {hi, rd, 7'b0110111};
  endfunction

  function automatic logic [31:0] branch_inst(input logic [12:0] off, input logic [4:0] rs2,
                                              input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] jal_inst(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  // called right after a rising edge, returns on the edge that takes the write
  task automatic write_gpr(input logic [4:0] addr, input logic [63:0] data);
    wb <= '{wen: 1'b1, waddr: addr, wdata: data};
    @(posedge clk);
    wb.wen <= 1'b0;
  endtask

  task automatic send_inst(input logic [31:0] inst, input logic [63:0] pc);
    int n;
    fs_valid <= 1'b1;
    fs_bus   <= '{inst: inst, pc: pc};
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!ds_allowin && n < 50);
    if (!ds_allowin) begin
      $display("Error: timeout waiting for the stage to accept an instruction");
      errors++;
    end
    fs_valid <= 1'b0;
  endtask

  // queue is looked at only on falling edges, after the compare process has run
  task automatic drain();
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (inflight.size() != 0 && n < 50);
    if (inflight.size() != 0) begin
      $display("Error: timeout waiting for the stage to empty");
      errors++;
    end
    @(posedge clk);
  endtask

  // compare process, one check per edge that holds a valid output
  always @(posedge clk) begin
    ds_to_es_t exp_bus;
    br_bus_t   exp_br;
    if (es_valid) begin
      if (inflight.size() == 0) begin
        $display("Error: stage output is valid with no instruction accepted");
        errors++;
      end else begin
        ref_decode(inflight[0].inst, inflight[0].pc, shadow_gpr, exp_bus, exp_br);
        check("o_ds_to_es_bus.rs1data", 512'(es_bus.rs1data), 512'(exp_bus.rs1data));
        check("o_ds_to_es_bus.rs2data", 512'(es_bus.rs2data), 512'(exp_bus.rs2data));
        check("o_ds_to_es_bus.pc", 512'(es_bus.pc), 512'(exp_bus.pc));
        check("o_ds_to_es_bus.ctrl", 512'(es_bus.ctrl), 512'(exp_bus.ctrl));
        check("o_br_bus.taken", 512'(br_bus.taken), 512'(exp_br.taken));
        check("o_br_bus.target", 512'(br_bus.target), 512'(exp_br.target));
        if (es_allowin) begin
          void'(inflight.pop_front());
          emitted++;
        end
      end
    end
    shadow_write(wb); // after the compare, the write lands on this edge
    if (fs_valid && ds_allowin) begin
      inflight.push_back(fs_bus);
      accepted++;
    end
  end

  initial begin
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [31:0] inst;
    logic [63:0] a;
    logic [63:0] pc;
    ds_to_es_t   held;
    void'($urandom(32'h55c2));
    arst_n     <= 1'b0;
    fs_valid   <= 1'b0;
    fs_bus     <= '0;
    es_allowin <= 1'b1;
    wb         <= '0;
    es_rd      <= '0;
    ms_rd      <= '0;
    ws_rd      <= '0;
    repeat (5) @(posedge clk);
    arst_n <= 1'b1;
    @(negedge clk);
    check("o_ds_to_es_valid", 512'(es_valid), 512'(1'b0));
    check("o_br_bus.taken", 512'(br_bus.taken), 512'(1'b0));
    check("o_ds_allowin", 512'(ds_allowin), 512'(1'b1));
    @(posedge clk);

    // x0 write is dropped by both sides
    for (int r = 0; r < 32; r++) begin
      write_gpr(5'(r), {$urandom, $urandom});
    end

    for (int k = 0; k < 24; k++) begin
      rs1 = (k < 6) ? 5'd0 : 5'($urandom); // first round reads x0
      rs2 = 5'($urandom);
      rd  = 5'($urandom);
      case (k % 6)
        0: inst = addi_inst(12'($urandom), rs1, rd);
        1: inst = alu_reg_inst(7'h00, rs2, rs1, 3'b000, rd);
        2: inst = alu_reg_inst(7'h20, rs2, rs1, 3'b000, rd);
        3: inst = alu_reg_inst(7'h00, rs2, rs1, 3'b111, rd);
        4: inst = alu_reg_inst(7'h00, rs2, rs1, 3'b110, rd);
        default: inst = lui_inst(20'($urandom), rd);
      endcase
      send_inst(inst, 64'(k * 4));
    end
    drain();

    // memory stage owes rs2
    ms_rd <= 5'd7;
    send_inst(alu_reg_inst(7'h00, 5'd7, 5'd3, 3'b000, 5'd9), 64'h1000);
    repeat (3) begin
      @(negedge clk);
      check("o_ds_to_es_valid", 512'(es_valid), 512'(1'b0));
      check("o_ds_allowin", 512'(ds_allowin), 512'(1'b0));
    end
    @(posedge clk);
    ms_rd <= '0;
    drain();

    es_rd <= 5'd12; // matches neither source
    send_inst(alu_reg_inst(7'h00, 5'd7, 5'd3, 3'b111, 5'd12), 64'h1004);
    @(negedge clk);
    check("o_ds_to_es_valid", 512'(es_valid), 512'(1'b1));
    @(posedge clk);
    es_rd <= '0;
    drain();

    es_allowin <= 1'b0;
    send_inst(alu_reg_inst(7'h20, 5'd5, 5'd6, 3'b000, 5'd2), 64'h2000);
    @(negedge clk);
    held = es_bus;
    repeat (3) begin
      @(negedge clk);
      check("o_ds_to_es_bus", 512'(es_bus), 512'(held));
      check("o_ds_allowin", 512'(ds_allowin), 512'(1'b0));
      check("o_ds_to_es_valid", 512'(es_valid), 512'(1'b1));
    end
    @(posedge clk);
    es_allowin <= 1'b1;
    drain();

    for (int k = 0; k < 16; k++) begin
      a = {$urandom, $urandom};
      write_gpr(5'd10, a);
      write_gpr(5'd11, (k < 4) ? a : {$urandom, $urandom}); // equal operands first
      pc = {$urandom, $urandom};
      pc[1:0] = 2'b00;
      // eq, ne, lt, ge in turn
      send_inst(branch_inst(13'($urandom), 5'd11, 5'd10, {k[1], 1'b0, k[0]}), pc);
    end
    repeat (4) begin
      send_inst(jal_inst(21'($urandom), 5'($urandom)), {32'h0, $urandom & 32'hffff_fffc});
    end
    drain();

    send_inst(32'h0000_3003, 64'h3000); // load
    send_inst(alu_reg_inst(7'h01, 5'd2, 5'd1, 3'b000, 5'd3), 64'h3004); // mul
    send_inst(branch_inst(13'h10, 5'd2, 5'd1, 3'b010), 64'h3008);
    drain();

    @(negedge clk);
    check("emitted instruction count", 512'(emitted), 512'(accepted));
    $display("errors %0d, accepted %0d, emitted %0d", errors, accepted, emitted);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+src
+incdir+tb
src/rv_isa_pkg.sv
src/id_bus_pkg.sv
src/id_gpr_file.sv
src/id_decoder.sv
src/id_branch_unit.sv
src/id_stage_ctrl.sv
src/id_stage.sv
tb/tb_id_stage.sv
